/* src/mult_pkg.sv */
package mult_pkg;

    ////////////////////
    // Bus types
    ////////////////////

    // Byte address and data word of the APB port
    typedef logic [4:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Master side of one APB transfer
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    // Slave side
    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    ////////////////////
    // Datapath control
    ////////////////////

    // Select code shared by both shift registers
    typedef enum logic [1:0] {
        SH_HOLD  = 2'b00,
        SH_LOAD  = 2'b01,
        SH_LEFT  = 2'b10,
        SH_RIGHT = 2'b11
    } shift_op_t;

    // Controller states
    typedef enum logic {
        ST_IDLE  = 1'b0,
        ST_SHIFT = 1'b1
    } ctrl_state_t;

    ////////////////////
    // Register map
    ////////////////////

    localparam apb_addr_t ADDR_OPA    = 5'h00;
    localparam apb_addr_t ADDR_OPB    = 5'h04;
    localparam apb_addr_t ADDR_CTRL   = 5'h08;
    localparam apb_addr_t ADDR_STATUS = 5'h0C;
    localparam apb_addr_t ADDR_RESULT = 5'h10;

endpackage

/* src/mcand_shifter.sv */
`timescale 1ns/1ps

// Multiplicand register, twice the operand width so it can move up
module mcand_shifter
    import mult_pkg::*;
#(
    parameter int OP_WIDTH = 16
)
(
    input  logic                    CLK,
    input  logic                    rst,
    input  shift_op_t               sel,
    input  logic [OP_WIDTH-1:0]     din,
    output logic [2*OP_WIDTH-1:0]   q
);

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            q <= '0;
        end
        else
        begin
            case (sel)
                // Operand lands in the low half, top half cleared
                SH_LOAD:
                begin
                    q <= {{OP_WIDTH{1'b0}}, din};
                end
                // Next partial product weight
                SH_LEFT:
                begin
                    q <= {q[2*OP_WIDTH-2:0], 1'b0};
                end
                // Hold, and SH_RIGHT never used on this register
                default:
                begin
                    q <= q;
                end
            endcase
        end
    end

endmodule

/* src/mplier_shifter.sv */
`timescale 1ns/1ps

// Multiplier register, consumed one bit per step from the bottom
module mplier_shifter
    import mult_pkg::*;
#(
    parameter int OP_WIDTH = 16
)
(
    input  logic                CLK,
    input  logic                rst,
    input  shift_op_t           sel,
    input  logic [OP_WIDTH-1:0] din,
    output logic                lsb,
    output logic                zero
);

    logic [OP_WIDTH-1:0] q;

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            q <= '0;
        end
        else
        begin
            case (sel)
                SH_LOAD:
                begin
                    q <= din;
                end
                // Drop the bit just used, zero fills from the top
                SH_RIGHT:
                begin
                    q <= {1'b0, q[OP_WIDTH-1:1]};
                end
                default:
                begin
                    q <= q;
                end
            endcase
        end
    end

    // Bit deciding the current add
    assign lsb  = q[0];

    // No ones left, so no more adds to do (early exit)
    assign zero = (q == '0);

endmodule

/* src/product_accum.sv */
`timescale 1ns/1ps

// Running sum of the shifted multiplicand
module product_accum
#(
    parameter int OP_WIDTH = 16
)
(
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    clr,
    input  logic                    acc_en,
    input  logic                    lsb,
    input  logic [2*OP_WIDTH-1:0]   addend,
    output logic [2*OP_WIDTH-1:0]   product
);

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            product <= '0;
        end
        // New operation starts from zero
        else if (clr)
        begin
            product <= '0;
        end
        // Add only for a one in the multiplier
        else if (acc_en && lsb)
        begin
            // Product of two OP_WIDTH operands never overflows
            product <= product + addend;
        end
        else
        begin
            product <= product;
        end
    end

endmodule

/* src/mult_ctrl.sv */
`timescale 1ns/1ps

// Two-state sequencer for the shift-and-add engine
module mult_ctrl
    import mult_pkg::*;
(
    input  logic      CLK,
    input  logic      rst,
    input  logic      start,
    input  logic      zero,
    output shift_op_t sel_a,
    output shift_op_t sel_b,
    output logic      clr,
    output logic      acc_en,
    output logic      busy,
    output logic      finish
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    ////////////////////
    // State register
    ////////////////////

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    ////////////////////
    // Next state and output decode
    ////////////////////

    always_comb
    begin
        // Quiet by default
        state_nxt = state;
        sel_a     = SH_HOLD;
        sel_b     = SH_HOLD;
        clr       = 1'b0;
        acc_en    = 1'b0;
        finish    = 1'b0;
        case (state)
            ST_IDLE:
            begin
                // Load both operands and clear the sum in the same cycle
                if (start)
                begin
                    sel_a     = SH_LOAD;
                    sel_b     = SH_LOAD;
                    clr       = 1'b1;
                    state_nxt = ST_SHIFT;
                end
            end
            ST_SHIFT:
            begin
                if (zero)
                begin
                    // Nothing left to add, product is final
                    finish    = 1'b1;
                    state_nxt = ST_IDLE;
                end
                else
                begin
                    // One add-and-shift step
                    acc_en = 1'b1;
                    sel_a  = SH_LEFT;
                    sel_b  = SH_RIGHT;
                end
            end
            default:
            begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    // Engine occupied for the whole shift phase
    assign busy = (state == ST_SHIFT);

endmodule

/* src/apb_mult_regs.sv */
`timescale 1ns/1ps

// APB register file in front of the multiplier, zero wait states
module apb_mult_regs
    import mult_pkg::*;
#(
    parameter int OP_WIDTH = 16
)
(
    input  logic                    CLK,
    input  logic                    rst,
    input  apb_req_t                apb_req,
    output apb_rsp_t                apb_rsp,
    input  logic                    busy,
    input  logic                    finish,
    input  logic [2*OP_WIDTH-1:0]   product,
    output logic [OP_WIDTH-1:0]     opa,
    output logic [OP_WIDTH-1:0]     opb,
    output logic                    start,
    output logic                    done
);

    logic      access;
    logic      err;
    logic      wr_ok;
    logic      start_acc;
    apb_data_t rdata;

    ////////////////////
    // Access decode
    ////////////////////

    // Second cycle of a transfer, pready is tied high so it always completes
    assign access = apb_req.psel && apb_req.penable;

    always_comb
    begin
        err   = 1'b0;
        rdata = '0;
        case (apb_req.paddr)
            ADDR_OPA:
            begin
                rdata[OP_WIDTH-1:0] = opa;
            end
            ADDR_OPB:
            begin
                rdata[OP_WIDTH-1:0] = opb;
            end
            ADDR_CTRL:
            begin
                // Start pulse still pending counts as busy too
                err = apb_req.pwrite && apb_req.pwdata[0] && (busy || start);
            end
            ADDR_STATUS:
            begin
                rdata[1:0] = {done, busy};
                err        = apb_req.pwrite;
            end
            ADDR_RESULT:
            begin
                rdata[2*OP_WIDTH-1:0] = product;
                err                   = apb_req.pwrite;
            end
            default:
            begin
                err = 1'b1;
            end
        endcase
    end

    // Refused writes leave every register alone
    assign wr_ok     = access && apb_req.pwrite && !err;
    assign start_acc = wr_ok && (apb_req.paddr == ADDR_CTRL) && apb_req.pwdata[0];

    assign apb_rsp = '{prdata: rdata, pready: 1'b1, pslverr: access && err};

    ////////////////////
    // Registers
    ////////////////////

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            opa   <= '0;
            opb   <= '0;
            start <= 1'b0;
            done  <= 1'b0;
        end
        else
        begin
            // Operands keep only their low bits
            if (wr_ok && (apb_req.paddr == ADDR_OPA))
            begin
                opa <= apb_req.pwdata[OP_WIDTH-1:0];
            end
            if (wr_ok && (apb_req.paddr == ADDR_OPB))
            begin
                opb <= apb_req.pwdata[OP_WIDTH-1:0];
            end
            // One cycle after the accepted access phase
            start <= start_acc;
            // Cleared by a new start, set when the engine finishes
            if (start_acc)
            begin
                done <= 1'b0;
            end
            else if (finish)
            begin
                done <= 1'b1;
            end
        end
    end

endmodule

/* src/apb_multiplier.sv */
`timescale 1ns/1ps

// APB shift-and-add multiplier, top level
module apb_multiplier
    import mult_pkg::*;
#(
    parameter int OP_WIDTH = 16
)
(
    input  logic     CLK,
    input  logic     rst,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    output logic     done
);

    // Bus side to engine
    logic                  start;
    logic [OP_WIDTH-1:0]   opa;
    logic [OP_WIDTH-1:0]   opb;
    logic                  busy;
    logic                  finish;
    logic [2*OP_WIDTH-1:0] product;

    // Controller to datapath
    shift_op_t             sel_a;
    shift_op_t             sel_b;
    logic                  clr;
    logic                  acc_en;

    // Datapath internals
    logic [2*OP_WIDTH-1:0] mcand;
    logic                  lsb;
    logic                  zero;

    apb_mult_regs #(.OP_WIDTH(OP_WIDTH)) u_regs (
        .CLK(CLK), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp),
        .busy(busy), .finish(finish), .product(product),
        .opa(opa), .opb(opb), .start(start), .done(done)
    );

    mult_ctrl u_ctrl (
        .CLK(CLK), .rst(rst), .start(start), .zero(zero),
        .sel_a(sel_a), .sel_b(sel_b), .clr(clr), .acc_en(acc_en),
        .busy(busy), .finish(finish)
    );

    ////////////////////
    // Datapath
    ////////////////////

    mcand_shifter #(.OP_WIDTH(OP_WIDTH)) u_mcand (
        .CLK(CLK), .rst(rst), .sel(sel_a), .din(opa), .q(mcand)
    );

    mplier_shifter #(.OP_WIDTH(OP_WIDTH)) u_mplier (
        .CLK(CLK), .rst(rst), .sel(sel_b), .din(opb), .lsb(lsb), .zero(zero)
    );

    product_accum #(.OP_WIDTH(OP_WIDTH)) u_accum (
        .CLK(CLK), .rst(rst), .clr(clr), .acc_en(acc_en), .lsb(lsb),
        .addend(mcand), .product(product)
    );

endmodule

/* verification/apb_multiplier_chk.sv */
`timescale 1ns/1ps

// Protocol and sequencing properties, bound into the top level
module apb_multiplier_chk
    import mult_pkg::*;
#(
    parameter int OP_WIDTH = 16
)
(
    input logic        CLK,
    input logic        rst,
    input apb_rsp_t    apb_rsp,
    input logic        start,
    input logic        busy,
    input logic        finish,
    input shift_op_t   sel_a,
    input shift_op_t   sel_b,
    input ctrl_state_t state
);

    // Cycles since the last start pulse while the engine runs
    int run_cnt;

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            run_cnt <= 0;
        end
        else if (start)
        begin
            run_cnt <= 1;
        end
        else if (busy)
        begin
            run_cnt <= run_cnt + 1;
        end
        else
        begin
            run_cnt <= 0;
        end
    end

    // No wait states
    assert property (@(posedge CLK) disable iff (rst) apb_rsp.pready)
    else $error("pready low");

    // OP_WIDTH steps plus the finish cycle at most
    assert property (@(posedge CLK) disable iff (rst) busy |-> (run_cnt <= OP_WIDTH + 1))
    else $error("busy held too long after start");

    assert property (@(posedge CLK) disable iff (rst)
        (sel_a == SH_LOAD || sel_b == SH_LOAD) |-> (state == ST_IDLE))
    else $error("operand load outside idle state");

    assert property (@(posedge CLK) disable iff (rst) !(finish && start))
    else $error("finish and start together");

endmodule

bind apb_multiplier apb_multiplier_chk #(.OP_WIDTH(OP_WIDTH)) u_chk (
    .CLK(CLK), .rst(rst), .apb_rsp(apb_rsp), .start(start), .busy(busy),
    .finish(finish), .sel_a(sel_a), .sel_b(sel_b), .state(u_ctrl.state)
);

/* verification/tb_apb_multiplier.sv */
`timescale 1ns/1ps

// Directed testbench for the APB shift-and-add multiplier
module tb_apb_multiplier
    import mult_pkg::*;
();

    logic        CLK;
    logic        rst;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        done;
    logic [31:0] rng;

    apb_multiplier #(.OP_WIDTH(16)) u_apb_multiplier (
        .CLK(CLK), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp), .done(done)
    );

    // 4 ns clock
    initial
    begin
        CLK = 1'b0;
        forever
        begin
            #2 CLK = ~CLK;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act == exp)
        else
        begin
            $display("ERROR %0t %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
            abort_run();
        end
    endtask

    // Setup and access phases driven 1 ns after the rising edge
    task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge CLK);
        #1;
        apb_req.penable = 1'b1;
        // Sample late in the access phase
        #2;
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        // Zero wait states so every access phase completes
        check_value("pready", 32'h1, 32'(apb_rsp.pready));
        @(posedge CLK);
        #1;
        apb_req = '0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        apb_data_t unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        apb_access(1'b0, addr, '0, data, err);
    endtask

    // Poll STATUS for done within 50 reads
    task automatic wait_done();
        apb_data_t st;
        logic      err;
        int        n;
        st = '0;
        n  = 0;
        while (!st[1] && n < 50)
        begin
            apb_read(ADDR_STATUS, st, err);
            n++;
        end
        assert (st[1])
        else
        begin
            $display("done flag never appeared in STATUS after 50 reads at %0t", $time);
            abort_run();
        end
    endtask

    // Full operation from operand writes to the result check
    task automatic run_product(input apb_data_t a, input apb_data_t b);
        apb_data_t rd;
        logic      err;
        apb_write(ADDR_OPA, a, err);
        check_value("pslverr", 32'h0, 32'(err));
        apb_write(ADDR_OPB, b, err);
        check_value("pslverr", 32'h0, 32'(err));
        // Operands keep only 16 bits
        apb_read(ADDR_OPA, rd, err);
        check_value("OPA", {16'h0, a[15:0]}, rd);
        apb_read(ADDR_OPB, rd, err);
        check_value("OPB", {16'h0, b[15:0]}, rd);
        apb_write(ADDR_CTRL, 32'h1, err);
        check_value("pslverr", 32'h0, 32'(err));
        wait_done();
        apb_read(ADDR_RESULT, rd, err);
        check_value("RESULT", {16'h0, a[15:0]} * {16'h0, b[15:0]}, rd);
        apb_read(ADDR_STATUS, rd, err);
        check_value("STATUS", 32'h2, rd);
        check_value("done", 32'h1, 32'(done));
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic reset_state();
        apb_data_t rd;
        logic      err;
        check_value("done", 32'h0, 32'(done));
        apb_read(ADDR_STATUS, rd, err);
        check_value("STATUS", 32'h0, rd);
        apb_read(ADDR_RESULT, rd, err);
        check_value("RESULT", 32'h0, rd);
        apb_read(ADDR_OPA, rd, err);
        check_value("OPA", 32'h0, rd);
        check_value("pslverr", 32'h0, 32'(err));
        apb_read(ADDR_OPB, rd, err);
        check_value("OPB", 32'h0, rd);
        check_value("pslverr", 32'h0, 32'(err));
    endtask

    task automatic directed_products();
        run_product(32'h0, 32'h5);
        run_product(32'h5, 32'h0);
        run_product(32'h1, 32'h1);
        run_product(32'h3, 32'h7);
        run_product(32'hFFFF, 32'hFFFF);
        run_product(32'h8000, 32'h2);
    endtask

    // Raw 32-bit values exercise the operand masking
    task automatic random_products();
        apb_data_t a;
        for (int i = 0; i < 40; i++)
        begin
            rng = next_random(rng);
            a   = rng;
            rng = next_random(rng);
            run_product(a, rng);
        end
    endtask

    task automatic start_while_busy();
        apb_data_t rd;
        logic      err;
        apb_write(ADDR_OPA, 32'h1234, err);
        apb_write(ADDR_OPB, 32'h8000, err);
        apb_write(ADDR_CTRL, 32'h1, err);
        check_value("pslverr", 32'h0, 32'(err));
        // Back-to-back start while the engine runs
        apb_write(ADDR_CTRL, 32'h1, err);
        check_value("pslverr", 32'h1, 32'(err));
        wait_done();
        apb_read(ADDR_RESULT, rd, err);
        check_value("RESULT", 32'h1234 * 32'h8000, rd);
    endtask

    task automatic bus_errors();
        apb_data_t rd;
        logic      err;
        run_product(32'h00AB, 32'h0033);
        apb_write(ADDR_STATUS, 32'hFFFF_FFFF, err);
        check_value("pslverr", 32'h1, 32'(err));
        apb_write(ADDR_RESULT, 32'hFFFF_FFFF, err);
        check_value("pslverr", 32'h1, 32'(err));
        apb_write(5'h14, 32'hFFFF_FFFF, err);
        check_value("pslverr", 32'h1, 32'(err));
        apb_read(5'h14, rd, err);
        check_value("pslverr", 32'h1, 32'(err));
        // Nothing moved
        apb_read(ADDR_OPA, rd, err);
        check_value("OPA", 32'h00AB, rd);
        apb_read(ADDR_OPB, rd, err);
        check_value("OPB", 32'h0033, rd);
        apb_read(ADDR_RESULT, rd, err);
        check_value("RESULT", 32'h00AB * 32'h0033, rd);
        apb_read(ADDR_STATUS, rd, err);
        check_value("STATUS", 32'h2, rd);
        // Long operation keeps done low while busy
        apb_write(ADDR_OPB, 32'h8000, err);
        apb_write(ADDR_CTRL, 32'h1, err);
        apb_read(ADDR_STATUS, rd, err);
        check_value("STATUS", 32'h1, rd);
        check_value("done", 32'h0, 32'(done));
        wait_done();
        apb_read(ADDR_RESULT, rd, err);
        check_value("RESULT", 32'h00AB * 32'h8000, rd);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial
    begin
        apb_req = '0;
        rst     = 1'b1;
        rng     = 32'h7cd3_88cc;
        repeat (5) @(posedge CLK);
        #1;
        rst = 1'b0;
        reset_state();
        directed_products();
        random_products();
        start_while_busy();
        bus_errors();
        $display("Testbench passed");
        $finish;
    end

endmodule

/* vlog.f */
src/mult_pkg.sv
src/mcand_shifter.sv
src/mplier_shifter.sv
src/product_accum.sv
src/mult_ctrl.sv
src/apb_mult_regs.sv
src/apb_multiplier.sv
verification/apb_multiplier_chk.sv
verification/tb_apb_multiplier.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/1ps --top-module tb_apb_multiplier \
    -f vlog.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "^Testbench passed$" &&
echo "run.sh: simulation ok" ||
{ echo "run.sh: simulation not ok"; exit 1; }
